//--- ll_consts.svh
`ifndef LL_CONSTS_SVH
`define LL_CONSTS_SVH

// PHY word and AR payload sizes
`define LL_PHY_W          80
`define LL_AR_PAYLOAD_W   49
// Receive FIFO depth, also the far side's starting credit
`define LL_DEPTH          8

// AXI AR field widths
`define LL_ID_W           4
`define LL_SIZE_W         3
`define LL_LEN_W          8
`define LL_BURST_W        2
`define LL_ADDR_W         32

// Field positions inside the AR payload
`define LL_ADDR_LSB       0
`define LL_BURST_LSB      32
`define LL_LEN_LSB        34
`define LL_SIZE_LSB       42
`define LL_ID_LSB         45

// PHY word bit positions
`define LL_PUSH_BIT       0
`define LL_PAYLOAD_LSB    1
`define LL_CREDIT_BIT     0

`endif

//--- ll_pkg.sv
`default_nettype none

`include "ll_consts.svh"

package ll_pkg;

  ////////////////////////////////////////////////////////////
  // Link level words

  // Raw 80-bit word on the PHY in either direction
  typedef logic [`LL_PHY_W-1:0]        phy_word_t;

  // Packed AR request as carried over the link
  typedef logic [`LL_AR_PAYLOAD_W-1:0] ar_payload_t;

  ////////////////////////////////////////////////////////////
  // AXI AR fields

  typedef logic [`LL_ID_W-1:0]         axi_id_t;
  typedef logic [`LL_SIZE_W-1:0]       axi_size_t;
  typedef logic [`LL_LEN_W-1:0]        axi_len_t;
  typedef logic [`LL_BURST_W-1:0]      axi_burst_t;
  typedef logic [`LL_ADDR_W-1:0]       axi_addr_t;

  // Occupancy for a FIFO of LL_DEPTH entries, 0 to LL_DEPTH inclusive
  typedef logic [$clog2(`LL_DEPTH+1)-1:0] fifo_cnt_t;

  // Issuer output stage
  typedef enum logic {
    ISSUE_IDLE,
    ISSUE_HOLD
  } issue_state_t;

endpackage

`default_nettype wire

//--- ll_link_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ll_link_if;
  import ll_pkg::*;

  // Receive direction, unpacker to FIFO
  logic        push;
  ar_payload_t payload;

  // Return direction, FIFO back to the unpacker and top level
  logic        credit;
  logic        overflow;

  modport unpack_mp (
    output push,
    output payload,
    input  credit
  );

  modport fifo_mp (
    input  push,
    input  payload,
    output credit,
    output overflow
  );

endinterface

`default_nettype wire

//--- ar_rx_unpack.sv
`timescale 1ns/1ps
`include "ll_consts.svh"
`default_nettype none

module ar_rx_unpack (
  input  logic              clk_wr,
  input  logic              rst_n,
  input  ll_pkg::phy_word_t rx_phy0,
  output ll_pkg::phy_word_t tx_phy0,
  ll_link_if.unpack_mp      link
);
  import ll_pkg::*;

  logic        push_q;
  ar_payload_t payload_q;
  phy_word_t   tx_next;

  ////////////////////////////////////////////////////////////
  // Receive side

  // Push bit is control, so it is cleared by reset
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      push_q <= 1'b0;
    end else begin
      push_q <= rx_phy0[`LL_PUSH_BIT];
    end
  end

  // Payload only matters when push_q is high
  always_ff @(posedge clk_wr) begin
    payload_q <= rx_phy0[`LL_PAYLOAD_LSB +: `LL_AR_PAYLOAD_W];
  end

  assign link.push    = push_q;
  assign link.payload = payload_q;

  ////////////////////////////////////////////////////////////
  // Transmit side

  // Only the credit bit is ever set on the return word
  always_comb begin
    tx_next = '0;
    tx_next[`LL_CREDIT_BIT] = link.credit;
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_next;
    end
  end

endmodule

`default_nettype wire

//--- ll_rx_fifo.sv
`timescale 1ns/1ps
`include "ll_consts.svh"
`default_nettype none

// DEPTH must be a power of two, at least 2
module ll_rx_fifo #(
  parameter int DEPTH = `LL_DEPTH
) (
  input  logic                clk_wr,
  input  logic                rst_n,
  ll_link_if.fifo_mp          link,
  input  logic                head_pop,
  output logic                head_valid,
  output ll_pkg::ar_payload_t head_payload
);
  import ll_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  ar_payload_t      mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             pop;
  logic             push_ok;
  logic             push_drop;
  logic             credit_q;
  logic             overflow_q;

  ////////////////////////////////////////////////////////////
  // Status and handshake decode

  assign full       = (count == CNT_W'(DEPTH));
  assign head_valid = (count != '0);
  assign pop        = head_valid && head_pop;

  // A full FIFO still takes a push when the head leaves on the same edge
  assign push_ok   = link.push && (!full || pop);
  assign push_drop = link.push && !push_ok;

  ////////////////////////////////////////////////////////////
  // Storage

  always_ff @(posedge clk_wr) begin
    if (push_ok) begin
      mem[wr_ptr] <= link.payload;
    end
  end

  assign head_payload = mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({push_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Credit return and overflow

  // One credit cycle per entry that leaves
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      credit_q   <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      credit_q <= pop;
      // Sticky until reset
      if (push_drop) begin
        overflow_q <= 1'b1;
      end
    end
  end

  assign link.credit   = credit_q;
  assign link.overflow = overflow_q;

endmodule

`default_nettype wire

//--- ar_issuer.sv
`timescale 1ns/1ps
`include "ll_consts.svh"
`default_nettype none

module ar_issuer (
  input  logic                clk_wr,
  input  logic                rst_n,
  input  logic                head_valid,
  input  ll_pkg::ar_payload_t head_payload,
  output logic                head_pop,
  output ll_pkg::axi_id_t     user_arid,
  output ll_pkg::axi_size_t   user_arsize,
  output ll_pkg::axi_len_t    user_arlen,
  output ll_pkg::axi_burst_t  user_arburst,
  output ll_pkg::axi_addr_t   user_araddr,
  output logic                user_arvalid,
  input  logic                user_arready
);
  import ll_pkg::*;

  issue_state_t state;
  logic         stage_free;

  ////////////////////////////////////////////////////////////
  // Stage control

  // Stage can take a new entry when empty or being accepted this cycle
  assign stage_free = (state == ISSUE_IDLE) || user_arready;
  assign head_pop   = stage_free && head_valid;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      state <= ISSUE_IDLE;
    end else begin
      case (state)
        ISSUE_IDLE: begin
          if (head_valid) begin
            state <= ISSUE_HOLD;
          end
        end
        ISSUE_HOLD: begin
          // Back to back issue when another entry is waiting
          if (user_arready && !head_valid) begin
            state <= ISSUE_IDLE;
          end
        end
        default: state <= ISSUE_IDLE;
      endcase
    end
  end

  assign user_arvalid = (state == ISSUE_HOLD);

  ////////////////////////////////////////////////////////////
  // AR field registers

  // Loaded only on a pop, so they hold while stalled
  always_ff @(posedge clk_wr) begin
    if (head_pop) begin
      user_araddr  <= head_payload[`LL_ADDR_LSB  +: `LL_ADDR_W];
      user_arburst <= head_payload[`LL_BURST_LSB +: `LL_BURST_W];
      user_arlen   <= head_payload[`LL_LEN_LSB   +: `LL_LEN_W];
      user_arsize  <= head_payload[`LL_SIZE_LSB  +: `LL_SIZE_W];
      user_arid    <= head_payload[`LL_ID_LSB    +: `LL_ID_W];
    end
  end

endmodule

`default_nettype wire

//--- axi_ar_slave_top.sv
`timescale 1ns/1ps
`include "ll_consts.svh"
`default_nettype none

module axi_ar_slave_top (
  input  logic               clk_wr,
  input  logic               rst_n,

  // PHY
  input  ll_pkg::phy_word_t  rx_phy0,
  output ll_pkg::phy_word_t  tx_phy0,

  // AXI AR master channel
  output ll_pkg::axi_id_t    user_arid,
  output ll_pkg::axi_size_t  user_arsize,
  output ll_pkg::axi_len_t   user_arlen,
  output ll_pkg::axi_burst_t user_arburst,
  output ll_pkg::axi_addr_t  user_araddr,
  output logic               user_arvalid,
  input  logic               user_arready,

  // Credit rule violation seen on the link
  output logic               ll_overflow
);
  import ll_pkg::*;

  ////////////////////////////////////////////////////////////
  // Interconnect

  logic        head_valid;
  logic        head_pop;
  ar_payload_t head_payload;

  ll_link_if u_link ();

  assign ll_overflow = u_link.overflow;

  ////////////////////////////////////////////////////////////
  // PHY unpack and credit return

  ar_rx_unpack u_unpack (
    .clk_wr  (clk_wr),
    .rst_n   (rst_n),
    .rx_phy0 (rx_phy0),
    .tx_phy0 (tx_phy0),
    .link    (u_link)
  );

  ////////////////////////////////////////////////////////////
  // Receive FIFO

  ll_rx_fifo #(
    .DEPTH (`LL_DEPTH)
  ) u_fifo (
    .clk_wr       (clk_wr),
    .rst_n        (rst_n),
    .link         (u_link),
    .head_pop     (head_pop),
    .head_valid   (head_valid),
    .head_payload (head_payload)
  );

  ////////////////////////////////////////////////////////////
  // AR issue

  ar_issuer u_issuer (
    .clk_wr       (clk_wr),
    .rst_n        (rst_n),
    .head_valid   (head_valid),
    .head_payload (head_payload),
    .head_pop     (head_pop),
    .user_arid    (user_arid),
    .user_arsize  (user_arsize),
    .user_arlen   (user_arlen),
    .user_arburst (user_arburst),
    .user_araddr  (user_araddr),
    .user_arvalid (user_arvalid),
    .user_arready (user_arready)
  );

endmodule

`default_nettype wire

//--- axi_ar_slave_chk.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ar_slave_chk (
  input  logic               clk_wr,
  input  logic               rst_n,
  input  ll_pkg::phy_word_t  tx_phy0,
  input  ll_pkg::axi_id_t    user_arid,
  input  ll_pkg::axi_size_t  user_arsize,
  input  ll_pkg::axi_len_t   user_arlen,
  input  ll_pkg::axi_burst_t user_arburst,
  input  ll_pkg::axi_addr_t  user_araddr,
  input  logic               user_arvalid,
  input  logic               user_arready,
  input  logic               ll_overflow
);
  import ll_pkg::*;

  int assert_fails = 0;

  // AXI rule, valid and fields hold until the ready edge
  a_ar_stable: assert property (@(posedge clk_wr) disable iff (!rst_n)
      user_arvalid && !user_arready |=> user_arvalid &&
      $stable({user_arid, user_arsize, user_arlen, user_arburst, user_araddr}))
    else begin
      assert_fails++;
      $error("AR channel changed before arready");
    end

  // Return word is cleared by reset
  a_tx_reset: assert property (@(posedge clk_wr) !rst_n |=> tx_phy0 == '0)
    else begin
      assert_fails++;
      $error("tx word not zero during reset");
    end

  // Overflow is sticky
  a_ovf_sticky: assert property (@(posedge clk_wr) disable iff (!rst_n) !$fell(ll_overflow))
    else begin
      assert_fails++;
      $error("overflow flag fell outside reset");
    end

endmodule

bind axi_ar_slave_top axi_ar_slave_chk u_chk (.*);

`default_nettype wire

//--- tb_axi_ar_slave.sv
`timescale 1ns/1ps
`include "ll_consts.svh"
`default_nettype none

module tb_axi_ar_slave;
  import ll_pkg::*;

  localparam int NUM        = 12;
  localparam int CLK_PERIOD = 8;
  localparam int ENTRY_MAX  = 64;
  // Latency, stream and overflow passes over the table, plus reset
  localparam int RUN_LIMIT  = ((2 * NUM + `LL_DEPTH + 2) * ENTRY_MAX + 60) * CLK_PERIOD;

  logic        clk_wr;
  logic        rst_n;
  phy_word_t   rx_phy0;
  phy_word_t   tx_phy0;
  axi_id_t     user_arid;
  axi_size_t   user_arsize;
  axi_len_t    user_arlen;
  axi_burst_t  user_arburst;
  axi_addr_t   user_araddr;
  logic        user_arvalid;
  logic        user_arready;
  logic        ll_overflow;

  // Stimulus table, addresses come from $random at start
  axi_id_t     id_tab    [NUM] = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 15};
  axi_size_t   size_tab  [NUM] = '{0, 1, 2, 3, 4, 5, 6, 7, 2, 3, 2, 1};
  axi_len_t    len_tab   [NUM] = '{0, 1, 3, 7, 15, 255, 8, 128, 64, 2, 31, 200};
  axi_burst_t  burst_tab [NUM] = '{1, 0, 2, 1, 1, 0, 2, 1, 3, 1, 0, 2};
  int          stall_tab [NUM] = '{0, 3, 20, 0, 0, 1, 25, 0, 2, 0, 0, 5};
  axi_addr_t   addr_tab  [NUM];

  integer      seed;
  int          credits;
  int          credit_cnt;
  int          acc_cnt;
  int          wait_cnt;
  int          errors;
  int          checks;
  int          tests;
  int          failed;
  int          gap;
  int          lat;
  int          err_mark;
  logic        hold_ready;
  logic        held_valid;
  ar_payload_t held;
  ar_payload_t exp_q[$];
  ar_payload_t got_q[$];

  axi_ar_slave_top u_dut (.*);

  initial begin
    clk_wr = 1'b0;
    forever #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
  end

  initial begin
    #(RUN_LIMIT);
    $display("Timeout: the tests did not finish within %0d ns", RUN_LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  task automatic check_value(
    input logic [127:0] got,
    input logic [127:0] exp,
    input string        msg
  );
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0d ns: %s (got %0h, expected %0h)", $time, msg, got, exp);
    end
  endtask

  // One clock: far-side credit model, then the AR sink
  task automatic step_cycle();
    ar_payload_t ar_now;
    @(posedge clk_wr);
    #1;
    ar_now = {user_arid, user_arsize, user_arlen, user_arburst, user_araddr};
    check_value(tx_phy0[`LL_PHY_W-1:1], '0, "tx word bits above the credit bit");
    if (tx_phy0[0]) begin
      credits++;
      credit_cnt++;
    end
    check_value(credits > `LL_DEPTH, 1'b0, "far side holds more credits than the depth");
    if (held_valid) begin
      check_value({user_arvalid, ar_now}, {1'b1, held}, "AR channel changed while stalled");
    end
    if (user_arvalid && !hold_ready && wait_cnt >= stall_tab[acc_cnt % NUM]) begin
      user_arready = 1'b1;
    end else begin
      user_arready = 1'b0;
      if (user_arvalid) wait_cnt++;
    end
    held_valid = user_arvalid && !user_arready;
    held       = ar_now;
    if (user_arvalid && user_arready) begin
      got_q.push_back(ar_now);
      acc_cnt++;
      wait_cnt = 0;
    end
  endtask

  task automatic push_entry(input int i, input logic keep);
    ar_payload_t pl;
    pl = {id_tab[i], size_tab[i], len_tab[i], burst_tab[i], addr_tab[i]};
    // Upper bits are unused on the link and carry noise
    rx_phy0        = '0;
    rx_phy0[79:50] = 30'($random(seed));
    rx_phy0[49:1]  = pl;
    rx_phy0[0]     = 1'b1;
    if (keep) exp_q.push_back(pl);
    credits--;
    step_cycle();
    rx_phy0 = '0;
  endtask

  task automatic drain_and_compare();
    while (got_q.size() < exp_q.size()) step_cycle();
    repeat (6) step_cycle();
    check_value(got_q.size(), exp_q.size(), "number of AR transfers");
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_value(got_q[i], exp_q[i], $sformatf("AR transfer %0d fields", i));
    end
    exp_q.delete();
    got_q.delete();
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors > err_mark) failed++;
    $display("Test %-12s %s", name, (errors > err_mark) ? "failed" : "passed");
    err_mark = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    rst_n        = 1'b0;
    rx_phy0      = '0;
    user_arready = 1'b0;
    seed         = 32'hddde;
    credits      = `LL_DEPTH;
    {credit_cnt, acc_cnt, wait_cnt, errors, checks, tests, failed, err_mark} = '0;
    hold_ready   = 1'b0;
    held_valid   = 1'b0;
    for (int i = 0; i < NUM; i++) addr_tab[i] = $random(seed);

    repeat (10) @(posedge clk_wr);
    #1 rst_n = 1'b1;
    check_value(user_arvalid, 1'b0, "arvalid after reset");
    check_value(ll_overflow, 1'b0, "overflow after reset");
    check_value(tx_phy0, '0, "tx word after reset");
    report_test("reset");

    // Single push into an idle design
    push_entry(0, 1'b1);
    lat = 1;
    while (!user_arvalid) begin
      step_cycle();
      lat++;
    end
    check_value(lat, 3, "cycles from push sample to arvalid");
    drain_and_compare();
    report_test("latency");

    // Credit-limited stream with long stalls
    for (int i = 1; i < NUM; i++) begin
      gap = $random(seed) & 32'h3;
      repeat (gap) step_cycle();
      while (credits == 0) step_cycle();
      push_entry(i, 1'b1);
    end
    drain_and_compare();
    check_value(credit_cnt, acc_cnt, "credits returned versus AR transfers");
    check_value(credits, `LL_DEPTH, "far side credits after stream");
    check_value(ll_overflow, 1'b0, "overflow during compliant stream");
    report_test("stream");

    // Issuer stage holds one entry beyond the FIFO, so the next push is dropped
    hold_ready = 1'b1;
    for (int i = 0; i < `LL_DEPTH + 2; i++) push_entry(i, i < `LL_DEPTH + 1);
    repeat (4) step_cycle();
    check_value(ll_overflow, 1'b1, "overflow after push into full FIFO");
    hold_ready = 1'b0;
    drain_and_compare();
    check_value(credits, `LL_DEPTH - 1, "credits after dropped push");
    check_value(ll_overflow, 1'b1, "overflow stays set");
    report_test("overflow");

    check_value(u_dut.u_chk.assert_fails, 0, "bound assertion failures");
    $display("Tests %0d, failed %0d, checks %0d, mismatches %0d", tests, failed, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
ll_pkg.sv
ll_link_if.sv
ar_rx_unpack.sv
ll_rx_fifo.sv
ar_issuer.sv
axi_ar_slave_top.sv
axi_ar_slave_chk.sv
tb_axi_ar_slave.sv
